/* cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	//////////////////////////////
	// Basic word types
	//////////////////////////////

	// Data, address and instruction word
	typedef logic [15:0] word_t;
	// One of sixteen registers
	typedef logic [3:0] reg_idx_t;

	// Fetch starts here out of reset
	localparam word_t RESET_PC = 16'h0000;
	// PC step, also the scale of memory and branch offsets
	localparam word_t WORD_BYTES = 16'd2;

	// Top nibble of every instruction
	// Codes 2, 7 and D are no-ops that write nothing
	typedef enum logic [3:0] {
		OP_ADD  = 4'h0,
		OP_SUB  = 4'h1,
		OP_RSV2 = 4'h2,
		OP_XOR  = 4'h3,
		OP_SLL  = 4'h4,
		OP_SRA  = 4'h5,
		OP_ROR  = 4'h6,
		OP_RSV7 = 4'h7,
		OP_LW   = 4'h8,
		OP_SW   = 4'h9,
		OP_LHB  = 4'ha,
		OP_LLB  = 4'hb,
		OP_B    = 4'hc,
		OP_RSVD = 4'hd,
		OP_PCS  = 4'he,
		OP_HLT  = 4'hf
	} opcode_t;

	// Z is the top bit, flag masks follow the same order
	typedef struct packed {
		logic z;
		logic v;
		logic n;
	} flags_t;

	// Branch condition in bits 11:9
	typedef enum logic [2:0] {
		CC_NE     = 3'd0,
		CC_EQ     = 3'd1,
		CC_GT     = 3'd2,
		CC_LT     = 3'd3,
		CC_GE     = 3'd4,
		CC_LE     = 3'd5,
		CC_OV     = 3'd6,
		CC_UNCOND = 3'd7
	} cond_t;

	//////////////////////////////
	// Instruction views
	//////////////////////////////

	// ALU ops, rd = rs op rt (or op imm for shifts)
	typedef struct packed {
		opcode_t  op;
		reg_idx_t rd;
		reg_idx_t rs;
		reg_idx_t rt;
	} instr_reg_t;

	// LW and SW, rt is data, rs is base
	typedef struct packed {
		opcode_t    op;
		reg_idx_t   rt;
		reg_idx_t   rs;
		logic [3:0] offset;
	} instr_mem_t;

	// LHB and LLB
	typedef struct packed {
		opcode_t    op;
		reg_idx_t   rd;
		logic [7:0] imm;
	} instr_byte_t;

	// B with a 9-bit word offset
	typedef struct packed {
		opcode_t    op;
		cond_t      cond;
		logic [8:0] offset;
	} instr_br_t;

	typedef union packed {
		instr_reg_t  r;
		instr_mem_t  m;
		instr_byte_t b;
		instr_br_t   br;
	} instr_u;

endpackage

`default_nettype wire

/* cpu_fwd_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface cpu_fwd_if;
	import cpu_pkg::*;

	// Result leaving execute this cycle
	logic     ex_valid;
	reg_idx_t ex_dest;
	word_t    ex_value;

	// Value the memory stage will write back
	logic     mem_valid;
	reg_idx_t mem_dest;
	word_t    mem_value;

	modport execute (output ex_valid, ex_dest, ex_value);

	modport memory (output mem_valid, mem_dest, mem_value);

	// Decode only looks, execute wins over memory
	modport decode (
		input ex_valid, ex_dest, ex_value,
		input mem_valid, mem_dest, mem_value
	);

endinterface

`default_nettype wire

/* cpu_alu.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_alu (
	input  wire cpu_pkg::opcode_t op,
	input  wire cpu_pkg::word_t   a,
	input  wire cpu_pkg::word_t   b,
	input  wire [3:0]             imm,
	output cpu_pkg::word_t        result,
	output cpu_pkg::flags_t       flags,
	output logic [2:0]            flag_mask
);
	import cpu_pkg::*;

	logic        sub;
	word_t       addend;
	word_t       raw;
	logic        ovf;
	word_t       sat;
	logic [31:0] rot;
	word_t       mem_off;

	// SUB is a + ~b + 1
	assign sub    = (op == OP_SUB);
	assign addend = sub ? ~b : b;
	assign raw    = a + addend + word_t'(sub);

	// Overflow when both addends agree in sign and the sum does not
	assign ovf = (a[15] == addend[15]) && (raw[15] != a[15]);
	// Clamp toward the sign of a
	assign sat = ovf ? (a[15] ? 16'h8000 : 16'h7fff) : raw;

	// Rotate by shifting a doubled copy
	assign rot = {a, a} >> imm;

	// Sign-extended offset in words, turned into bytes
	assign mem_off = {{12{imm[3]}}, imm} * WORD_BYTES;

	always_comb begin
		result    = '0;
		flag_mask = 3'b000;
		case (op)
			OP_ADD, OP_SUB: begin
				result    = sat;
				flag_mask = 3'b111;
			end
			OP_XOR: begin
				result    = a ^ b;
				flag_mask = 3'b100;
			end
			OP_SLL: begin
				result    = a << imm;
				flag_mask = 3'b100;
			end
			OP_SRA: begin
				result    = $signed(a) >>> imm;
				flag_mask = 3'b100;
			end
			OP_ROR: begin
				result    = rot[15:0];
				flag_mask = 3'b100;
			end
			// Word aligned base plus offset
			OP_LW, OP_SW: result = {a[15:1], 1'b0} + mem_off;
			default: result = '0;
		endcase
	end

	assign flags = '{z: (result == '0), v: ovf, n: result[15]};

endmodule

`default_nettype wire

/* cpu_fetch.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_fetch (
	input  wire                    clk,
	input  wire                    arst_n,
	input  wire cpu_pkg::word_t    instr,
	input  wire cpu_pkg::opcode_t  ex_op,
	input  wire                    ex_ok,
	input  wire cpu_pkg::opcode_t  mem_op,
	input  wire                    mem_ok,
	input  wire                    br_taken,
	input  wire cpu_pkg::word_t    br_target,
	output cpu_pkg::word_t         pc,
	output logic                   stall,
	output logic                   id_valid,
	output cpu_pkg::instr_u        id_instr,
	output cpu_pkg::word_t         id_pc2
);
	import cpu_pkg::*;

	instr_u fetched;
	word_t  pc_plus2;
	logic   halt_seen;

	// Results that bypass cannot supply early enough
	// B also needs its shadow held until the redirect lands
	function automatic logic holds_decode(opcode_t op);
		return op inside {OP_B, OP_LW, OP_LHB, OP_LLB};
	endfunction

	assign fetched  = instr;
	assign pc_plus2 = pc + WORD_BYTES;

	// A fetched HLT parks the pc on itself
	assign halt_seen = (fetched.r.op == OP_HLT);

	// Two cycles of hold per hazard instruction, one per stage
	assign stall = (ex_ok && holds_decode(ex_op)) ||
		(mem_ok && holds_decode(mem_op));

	//////////////////////////////
	// Program counter
	//////////////////////////////

	// Redirect beats both the hazard hold and the halt hold
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= RESET_PC;
		end else if (br_taken) begin
			pc <= br_target;
		end else if (!stall && !halt_seen) begin
			pc <= pc_plus2;
		end
	end

	//////////////////////////////
	// Fetch/decode register
	//////////////////////////////

	// Kill the word fetched in the branch shadow
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_valid <= 1'b0;
		end else if (br_taken) begin
			id_valid <= 1'b0;
		end else if (!stall) begin
			id_valid <= 1'b1;
		end
	end

	// Word and return address, held with the pc
	always_ff @(posedge clk) begin
		if (!stall) begin
			id_instr <= fetched;
			id_pc2   <= pc_plus2;
		end
	end

endmodule

`default_nettype wire

/* cpu_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_decode (
	input  wire                    clk,
	input  wire                    arst_n,
	input  wire                    id_valid,
	input  wire cpu_pkg::instr_u   id_instr,
	input  wire cpu_pkg::word_t    id_pc2,
	input  wire                    stall,
	input  wire                    wb_we,
	input  wire cpu_pkg::reg_idx_t wb_dest,
	input  wire cpu_pkg::word_t    wb_value,
	cpu_fwd_if.decode              fwd,
	output logic                   ex_valid,
	output cpu_pkg::instr_u        ex_instr,
	output cpu_pkg::word_t         ex_pc2,
	output cpu_pkg::word_t         ex_a,
	output cpu_pkg::word_t         ex_b
);
	import cpu_pkg::*;

	// Sixteen general registers
	word_t    rf [16];
	// Source numbers and resolved operands, index 0 is a, 1 is b
	reg_idx_t src [2];
	word_t    opnd [2];

	//////////////////////////////
	// Register file
	//////////////////////////////

	// r0 gets written like any other, reads mask it to zero
	always_ff @(posedge clk) begin
		if (wb_we) begin
			rf[wb_dest] <= wb_value;
		end
	end

	//////////////////////////////
	// Operand select and bypass
	//////////////////////////////

	always_comb begin
		// First source is always bits 7:4
		src[0] = id_instr.r.rs;
		// Opcodes 0 to 7 read rt, the rest read bits 11:8
		// (SW data, old rd for LHB and LLB)
		src[1] = id_instr.r.op[3] ? id_instr.m.rt : id_instr.r.rt;

		for (int i = 0; i < 2; i++) begin
			if (src[i] == '0) begin
				opnd[i] = '0;
			end else if (fwd.ex_valid && (fwd.ex_dest == src[i])) begin
				// Youngest result first
				opnd[i] = fwd.ex_value;
			end else if (fwd.mem_valid && (fwd.mem_dest == src[i])) begin
				opnd[i] = fwd.mem_value;
			end else if (wb_we && (wb_dest == src[i])) begin
				// Write-through of this cycle's write-back
				opnd[i] = wb_value;
			end else begin
				opnd[i] = rf[src[i]];
			end
		end
	end

	//////////////////////////////
	// Decode/execute register
	//////////////////////////////

	// Stall turns this slot into a bubble
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_valid <= 1'b0;
		end else begin
			ex_valid <= id_valid && !stall;
		end
	end

	always_ff @(posedge clk) begin
		ex_instr <= id_instr;
		ex_pc2   <= id_pc2;
		ex_a     <= opnd[0];
		ex_b     <= opnd[1];
	end

endmodule

`default_nettype wire

/* cpu_execute.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_execute (
	input  wire                  clk,
	input  wire                  arst_n,
	input  wire                  ex_valid,
	input  wire cpu_pkg::instr_u ex_instr,
	input  wire cpu_pkg::word_t  ex_pc2,
	input  wire cpu_pkg::word_t  ex_a,
	input  wire cpu_pkg::word_t  ex_b,
	cpu_fwd_if.execute           fwd,
	output logic                 br_taken,
	output cpu_pkg::word_t       br_target,
	output logic                 mem_valid,
	output cpu_pkg::instr_u      mem_instr,
	output cpu_pkg::word_t       mem_pc2,
	output cpu_pkg::word_t       mem_result,
	output cpu_pkg::word_t       mem_store
);
	import cpu_pkg::*;

	opcode_t    op;
	word_t      alu_result;
	flags_t     alu_flags;
	logic [2:0] flag_mask;
	flags_t     flags_q;
	logic       cond_met;
	logic       fwd_op;

	assign op = ex_instr.r.op;

	// Bits 3:0 are both shift amount and memory offset
	cpu_alu alu_i (
		.op        (op),
		.a         (ex_a),
		.b         (ex_b),
		.imm       (ex_instr.m.offset),
		.result    (alu_result),
		.flags     (alu_flags),
		.flag_mask (flag_mask)
	);

	// Only bits named by the mask move
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			flags_q <= '0;
		end else if (ex_valid) begin
			flags_q <= flags_t'((flags_q & ~flag_mask) | (alu_flags & flag_mask));
		end
	end

	//////////////////////////////
	// Branch
	//////////////////////////////

	always_comb begin
		cond_met = 1'b0;
		case (ex_instr.br.cond)
			CC_NE:     cond_met = !flags_q.z;
			CC_EQ:     cond_met = flags_q.z;
			CC_GT:     cond_met = !flags_q.z && !flags_q.n;
			CC_LT:     cond_met = flags_q.n;
			CC_GE:     cond_met = flags_q.z || !flags_q.n;
			CC_LE:     cond_met = flags_q.z || flags_q.n;
			CC_OV:     cond_met = flags_q.v;
			CC_UNCOND: cond_met = 1'b1;
			default:   cond_met = 1'b0;
		endcase
	end

	assign br_taken  = ex_valid && (op == OP_B) && cond_met;
	// Relative to the next instruction
	assign br_target = ex_pc2 + {{7{ex_instr.br.offset[8]}}, ex_instr.br.offset} * WORD_BYTES;

	// PCS rides along so a reader right behind it sees pc+2
	assign fwd_op = op inside {OP_ADD, OP_SUB, OP_XOR, OP_SLL, OP_SRA, OP_ROR, OP_PCS};

	assign fwd.ex_valid = ex_valid && fwd_op;
	assign fwd.ex_dest  = ex_instr.r.rd;
	assign fwd.ex_value = (op == OP_PCS) ? ex_pc2 : alu_result;

	// Execute/memory register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem_valid <= 1'b0;
		end else begin
			mem_valid <= ex_valid;
		end
	end

	always_ff @(posedge clk) begin
		mem_instr  <= ex_instr;
		mem_pc2    <= ex_pc2;
		mem_result <= alu_result;
		mem_store  <= ex_b;
	end

endmodule

`default_nettype wire

/* cpu_memory.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_memory (
	input  wire                  clk,
	input  wire                  arst_n,
	input  wire                  mem_valid,
	input  wire cpu_pkg::instr_u mem_instr,
	input  wire cpu_pkg::word_t  mem_pc2,
	input  wire cpu_pkg::word_t  mem_result,
	input  wire cpu_pkg::word_t  mem_store,
	input  wire cpu_pkg::word_t  dmem_rdata,
	cpu_fwd_if.memory            fwd,
	output cpu_pkg::word_t       dmem_addr,
	output cpu_pkg::word_t       dmem_wdata,
	output logic                 dmem_wr,
	output logic                 wb_we,
	output cpu_pkg::reg_idx_t    wb_dest,
	output cpu_pkg::word_t       wb_value,
	output logic                 hlt
);
	import cpu_pkg::*;

	opcode_t op;
	logic    writes_reg;
	word_t   wb_sel;
	logic    wb_hlt;

	assign op = mem_instr.r.op;

	// Everything with a destination in bits 11:8
	assign writes_reg = op inside {OP_ADD, OP_SUB, OP_XOR, OP_SLL, OP_SRA, OP_ROR,
		OP_LW, OP_LHB, OP_LLB, OP_PCS};

	// Data port, address from the ALU
	assign dmem_addr  = mem_result;
	assign dmem_wdata = mem_store;
	assign dmem_wr    = mem_valid && (op == OP_SW);

	// mem_store holds old rd for the byte loads
	always_comb begin
		case (op)
			OP_LW:   wb_sel = dmem_rdata;
			OP_LHB:  wb_sel = {mem_instr.b.imm, mem_store[7:0]};
			OP_LLB:  wb_sel = {mem_store[15:8], mem_instr.b.imm};
			OP_PCS:  wb_sel = mem_pc2;
			default: wb_sel = mem_result;
		endcase
	end

	assign fwd.mem_valid = mem_valid && writes_reg;
	assign fwd.mem_dest  = mem_instr.r.rd;
	assign fwd.mem_value = wb_sel;

	//////////////////////////////
	// Memory/write-back register
	//////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_we  <= 1'b0;
			wb_hlt <= 1'b0;
		end else begin
			wb_we  <= mem_valid && writes_reg;
			wb_hlt <= mem_valid && (op == OP_HLT);
		end
	end

	always_ff @(posedge clk) begin
		wb_dest  <= mem_instr.r.rd;
		wb_value <= wb_sel;
	end

	// Sticky once an HLT leaves write-back
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hlt <= 1'b0;
		end else if (wb_hlt) begin
			hlt <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* cpu.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu (
	input  wire                  clk,
	input  wire                  arst_n,
	output wire cpu_pkg::word_t  pc,
	input  wire cpu_pkg::word_t  instr,
	output wire cpu_pkg::word_t  dmem_addr,
	output wire cpu_pkg::word_t  dmem_wdata,
	output wire                  dmem_wr,
	input  wire cpu_pkg::word_t  dmem_rdata,
	output wire                  hlt
);
	import cpu_pkg::*;

	// Hazard hold and branch redirect
	logic     stall;
	logic     br_taken;
	word_t    br_target;

	// Fetch to decode
	logic     id_valid;
	instr_u   id_instr;
	word_t    id_pc2;

	// Decode to execute
	logic     ex_valid;
	instr_u   ex_instr;
	word_t    ex_pc2;
	word_t    ex_a;
	word_t    ex_b;

	// Execute to memory
	logic     mem_valid;
	instr_u   mem_instr;
	word_t    mem_pc2;
	word_t    mem_result;
	word_t    mem_store;

	// Register file write port
	logic     wb_we;
	reg_idx_t wb_dest;
	word_t    wb_value;

	cpu_fwd_if fwd_if ();

	//////////////////////////////
	// Stages
	//////////////////////////////

	// Fetch sees the opcodes of execute and memory for the hazard rule
	cpu_fetch fetch_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.instr     (instr),
		.ex_op     (ex_instr.r.op),
		.ex_ok     (ex_valid),
		.mem_op    (mem_instr.r.op),
		.mem_ok    (mem_valid),
		.br_taken  (br_taken),
		.br_target (br_target),
		.pc        (pc),
		.stall     (stall),
		.id_valid  (id_valid),
		.id_instr  (id_instr),
		.id_pc2    (id_pc2)
	);

	cpu_decode decode_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.id_valid (id_valid),
		.id_instr (id_instr),
		.id_pc2   (id_pc2),
		.stall    (stall),
		.wb_we    (wb_we),
		.wb_dest  (wb_dest),
		.wb_value (wb_value),
		.fwd      (fwd_if),
		.ex_valid (ex_valid),
		.ex_instr (ex_instr),
		.ex_pc2   (ex_pc2),
		.ex_a     (ex_a),
		.ex_b     (ex_b)
	);

	cpu_execute execute_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.ex_valid   (ex_valid),
		.ex_instr   (ex_instr),
		.ex_pc2     (ex_pc2),
		.ex_a       (ex_a),
		.ex_b       (ex_b),
		.fwd        (fwd_if),
		.br_taken   (br_taken),
		.br_target  (br_target),
		.mem_valid  (mem_valid),
		.mem_instr  (mem_instr),
		.mem_pc2    (mem_pc2),
		.mem_result (mem_result),
		.mem_store  (mem_store)
	);

	// Data port and write-back both come out of memory
	cpu_memory memory_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.mem_valid  (mem_valid),
		.mem_instr  (mem_instr),
		.mem_pc2    (mem_pc2),
		.mem_result (mem_result),
		.mem_store  (mem_store),
		.dmem_rdata (dmem_rdata),
		.fwd        (fwd_if),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_wr    (dmem_wr),
		.wb_we      (wb_we),
		.wb_dest    (wb_dest),
		.wb_value   (wb_value),
		.hlt        (hlt)
	);

endmodule

`default_nettype wire

/* cpu_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_assert (
	input wire                 clk,
	input wire                 arst_n,
	input wire cpu_pkg::word_t pc,
	input wire                 hlt,
	input wire                 dmem_wr
);

	// Failed checks so far, the testbench reads this at the end
	int unsigned fail_count = 0;

	// Fresh out of reset the core has not halted
	hlt_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> !hlt)
		else begin fail_count++; $error("hlt high right after reset"); end

	// Only reset clears a halt
	hlt_sticky: assert property (@(posedge clk) disable iff (!arst_n) hlt |=> hlt)
		else begin fail_count++; $error("hlt fell without reset"); end

	// Fetch addresses are whole words
	pc_even: assert property (@(posedge clk) disable iff (!arst_n) !pc[0])
		else begin fail_count++; $error("pc is odd"); end

	no_store_halted: assert property (@(posedge clk) disable iff (!arst_n) hlt |-> !dmem_wr)
		else begin fail_count++; $error("store strobe while halted"); end

endmodule

bind cpu cpu_assert assert_i (
	.clk     (clk),
	.arst_n  (arst_n),
	.pc      (pc),
	.hlt     (hlt),
	.dmem_wr (dmem_wr)
);

`default_nettype wire

/* cpu_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_tb;
	import cpu_pkg::*;

	// POS and NEG operand shapes push ADD and SUB into saturation
	typedef enum logic [1:0] {SEL_RAND, SEL_POS, SEL_NEG, SEL_EQUAL} sel_t;
	typedef enum logic [2:0] {K_ALU, K_CHAIN, K_MEM, K_BRANCH, K_PCS, K_HALT} kind_t;

	// In branch rows op sets the flags and imm[2:0] holds the condition
	typedef struct {
		opcode_t    op;
		sel_t       sel;
		logic [3:0] imm;
		kind_t      kind;
	} row_t;

	localparam int HALT_TIMEOUT = 400;
	localparam int HOLD_CYCLES = 6;
	localparam word_t NOT_TAKEN_MARK = 16'h1d1d;
	localparam word_t TAKEN_MARK = 16'h7b7b;

	logic  clk;
	logic  arst_n;
	word_t instr;
	word_t dmem_rdata;
	wire word_t pc;
	wire word_t dmem_addr;
	wire word_t dmem_wdata;
	wire        dmem_wr;
	wire        hlt;

	word_t imem [64];
	word_t dmem [32768];
	word_t prog [$];
	word_t exp_addr [$];
	word_t exp_data [$];
	word_t st_addr [$];
	word_t st_data [$];
	word_t halt_pc;

	row_t rows [$] = '{
		'{OP_ADD, SEL_RAND, 4'd0, K_ALU},
		'{OP_ADD, SEL_POS, 4'd0, K_ALU},
		'{OP_ADD, SEL_NEG, 4'd0, K_ALU},
		'{OP_SUB, SEL_RAND, 4'd0, K_ALU},
		'{OP_SUB, SEL_POS, 4'd0, K_ALU},
		'{OP_SUB, SEL_NEG, 4'd0, K_ALU},
		'{OP_SUB, SEL_EQUAL, 4'd0, K_ALU},
		'{OP_XOR, SEL_RAND, 4'd0, K_ALU},
		'{OP_SLL, SEL_RAND, 4'd5, K_ALU},
		'{OP_SLL, SEL_RAND, 4'd0, K_ALU},
		'{OP_SRA, SEL_NEG, 4'd7, K_ALU},
		'{OP_SRA, SEL_POS, 4'd15, K_ALU},
		'{OP_ROR, SEL_RAND, 4'd3, K_ALU},
		'{OP_ROR, SEL_RAND, 4'd12, K_ALU},
		'{OP_XOR, SEL_RAND, 4'd1, K_CHAIN},
		'{OP_XOR, SEL_RAND, 4'd9, K_CHAIN},
		'{OP_SW, SEL_RAND, 4'd3, K_MEM},
		'{OP_SW, SEL_RAND, 4'hd, K_MEM},
		'{OP_SW, SEL_RAND, 4'd0, K_MEM},
		'{OP_SUB, SEL_EQUAL, 4'(CC_EQ), K_BRANCH},
		'{OP_SUB, SEL_EQUAL, 4'(CC_NE), K_BRANCH},
		'{OP_SUB, SEL_RAND, 4'(CC_GT), K_BRANCH},
		'{OP_SUB, SEL_POS, 4'(CC_GT), K_BRANCH},
		'{OP_SUB, SEL_RAND, 4'(CC_LT), K_BRANCH},
		'{OP_ADD, SEL_NEG, 4'(CC_GE), K_BRANCH},
		'{OP_ADD, SEL_RAND, 4'(CC_LE), K_BRANCH},
		'{OP_ADD, SEL_POS, 4'(CC_OV), K_BRANCH},
		'{OP_XOR, SEL_RAND, 4'(CC_OV), K_BRANCH},
		'{OP_XOR, SEL_EQUAL, 4'(CC_UNCOND), K_BRANCH},
		'{OP_PCS, SEL_RAND, 4'd0, K_PCS},
		'{OP_HLT, SEL_RAND, 4'd0, K_HALT}
	};

	cpu cpu_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.pc         (pc),
		.instr      (instr),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_wr    (dmem_wr),
		.dmem_rdata (dmem_rdata),
		.hlt        (hlt)
	);

	always #50 clk = ~clk;

	//////////////////////////////
	// Memory models
	//////////////////////////////

	// Both memories answer for the address of this cycle
	always @(posedge clk) begin
		#1;
		instr      = imem[pc[6:1]];
		dmem_rdata = dmem[dmem_addr[15:1]];
	end

	// Stores land and get logged mid-cycle
	always @(negedge clk) begin
		if (arst_n === 1'b1 && dmem_wr === 1'b1) begin
			dmem[dmem_addr[15:1]] = dmem_wdata;
			st_addr.push_back(dmem_addr);
			st_data.push_back(dmem_wdata);
		end
	end

	//////////////////////////////
	// Failure reporting
	//////////////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %0t %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic check_addr(input string name, input word_t got, input word_t exp);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %0t %s got %h expected %h", $time, name, got, exp));
	endtask

	always @(negedge clk) begin
		if (cpu_i.assert_i.fail_count != 0)
			abort_run("A property of the bound checker failed");
	end

	//////////////////////////////
	// Program builder
	//////////////////////////////

	function automatic word_t enc_reg(opcode_t op, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
		return {op, rd, rs, rt};
	endfunction

	function automatic word_t enc_mem(opcode_t op, reg_idx_t rt, reg_idx_t rs,
		logic [3:0] off);
		return {op, rt, rs, off};
	endfunction

	function automatic word_t enc_byte(opcode_t op, reg_idx_t rd, logic [7:0] imm);
		return {op, rd, imm};
	endfunction

	function automatic word_t enc_br(cond_t cond, logic [8:0] off);
		return {OP_B, cond, off};
	endfunction

	task automatic emit(input word_t w);
		prog.push_back(w);
	endtask

	// LLB sets the low byte first and LHB then keeps it
	task automatic load_const(input reg_idx_t rd, input word_t v);
		emit(enc_byte(OP_LLB, rd, v[7:0]));
		emit(enc_byte(OP_LHB, rd, v[15:8]));
	endtask

	task automatic expect_store(input word_t addr, input word_t data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	//////////////////////////////
	// Reference model
	//////////////////////////////

	task automatic pick_operands(input opcode_t op, input sel_t sel, output word_t a,
		output word_t b);
		word_t r1;
		word_t r2;
		r1 = word_t'($urandom);
		r2 = word_t'($urandom);
		case (sel)
			SEL_POS: begin
				a = 16'h6000 | r1[11:0];
				b = (op == OP_SUB) ? (16'h9000 | r2[11:0]) : (16'h6000 | r2[11:0]);
			end
			SEL_NEG: begin
				a = 16'h9000 | r1[11:0];
				b = (op == OP_SUB) ? (16'h6000 | r2[11:0]) : (16'h9000 | r2[11:0]);
			end
			SEL_EQUAL: begin
				a = r1;
				b = r1;
			end
			default: begin
				a = r1;
				b = r2;
			end
		endcase
	endtask

	// Exact signed sum or difference before clamping
	function automatic int sum_wide(opcode_t op, word_t a, word_t b);
		int s;
		s = int'($signed(a));
		if (op == OP_SUB)
			s = s - int'($signed(b));
		else
			s = s + int'($signed(b));
		return s;
	endfunction

	function automatic word_t model_alu(opcode_t op, word_t a, word_t b, logic [3:0] sh);
		int    s;
		word_t r;
		r = a;
		case (op)
			OP_ADD, OP_SUB: begin
				s = sum_wide(op, a, b);
				if (s > 32767)
					s = 32767;
				else if (s < -32768)
					s = -32768;
				r = word_t'(s);
			end
			OP_XOR: r = a ^ b;
			// One bit position per step
			OP_SLL: repeat (sh) r = {r[14:0], 1'b0};
			OP_SRA: repeat (sh) r = {r[15], r[15:1]};
			OP_ROR: repeat (sh) r = {r[0], r[15:1]};
			default: r = '0;
		endcase
		return r;
	endfunction

	function automatic flags_t model_flags(opcode_t op, word_t a, word_t b, flags_t prev);
		flags_t f;
		word_t  r;
		int     s;
		f = prev;
		r = model_alu(op, a, b, 4'd0);
		if (op inside {OP_ADD, OP_SUB}) begin
			s = sum_wide(op, a, b);
			f.z = (r == 16'h0000);
			f.v = (s > 32767) || (s < -32768);
			f.n = r[15];
		end else if (op == OP_XOR) begin
			f.z = (r == 16'h0000);
		end
		return f;
	endfunction

	function automatic logic cond_holds(cond_t c, flags_t f);
		case (c)
			CC_NE: return !f.z;
			CC_EQ: return f.z;
			CC_GT: return !f.z && !f.n;
			CC_LT: return f.n;
			CC_GE: return f.z || !f.n;
			CC_LE: return f.z || f.n;
			CC_OV: return f.v;
			default: return 1'b1;
		endcase
	endfunction

	//////////////////////////////
	// Per-row program and expectations
	//////////////////////////////

	task automatic build_program(input row_t r);
		word_t  a;
		word_t  b;
		word_t  base;
		int     addr;
		int     pos;
		flags_t f;
		prog.delete();
		exp_addr.delete();
		exp_data.delete();
		pick_operands(r.op, r.sel, a, b);
		case (r.kind)
			K_ALU: begin
				load_const(1, a);
				load_const(2, b);
				// Shifts carry the amount where rt would sit
				emit(enc_reg(r.op, 3, 1, (r.op inside {OP_SLL, OP_SRA, OP_ROR}) ? r.imm : 4'd2));
				emit(enc_mem(OP_SW, 3, 0, 4'd0));
				expect_store(16'h0000, model_alu(r.op, a, b, r.imm));
			end
			K_CHAIN: begin
				load_const(1, a);
				load_const(2, b);
				// Each reads the one before and the last XOR also reads two back
				emit(enc_reg(OP_XOR, 3, 1, 2));
				emit(enc_reg(OP_XOR, 4, 3, 1));
				emit(enc_reg(OP_XOR, 5, 4, 3));
				emit(enc_reg(OP_SLL, 6, 5, r.imm));
				emit(enc_mem(OP_SW, 6, 0, 4'd4));
				emit(enc_mem(OP_SW, 1, 0, 4'd0));
				emit(enc_mem(OP_SW, 3, 0, 4'd1));
				emit(enc_mem(OP_SW, 4, 0, 4'd2));
				emit(enc_mem(OP_SW, 5, 0, 4'd3));
				expect_store(16'd8, model_alu(OP_SLL, a, b, r.imm));
				expect_store(16'd0, a);
				expect_store(16'd2, a ^ b);
				expect_store(16'd4, b);
				expect_store(16'd6, a);
			end
			K_MEM: begin
				// Odd bases too since bit 0 of the base is dropped
				base = {8'h01, a[7:0]};
				load_const(1, b);
				load_const(4, base);
				emit(enc_mem(OP_SW, 1, 4, r.imm));
				emit(enc_mem(OP_LW, 5, 4, r.imm));
				emit(enc_mem(OP_SW, 5, 0, 4'd7));
				addr = int'(base & 16'hfffe) + 2 * int'($signed(r.imm));
				expect_store(word_t'(addr), b);
				expect_store(16'd14, b);
			end
			K_BRANCH: begin
				load_const(1, a);
				load_const(2, b);
				load_const(7, NOT_TAKEN_MARK);
				load_const(8, TAKEN_MARK);
				emit(enc_reg(r.op, 3, 1, 2));
				// Skip the marker store and the HLT after it
				emit(enc_br(cond_t'(r.imm[2:0]), 9'd2));
				emit(enc_mem(OP_SW, 7, 0, 4'd1));
				pos = prog.size();
				emit({OP_HLT, 12'h000});
				emit(enc_mem(OP_SW, 8, 0, 4'd2));
				emit({OP_HLT, 12'h000});
				f = model_flags(r.op, a, b, '0);
				if (cond_holds(cond_t'(r.imm[2:0]), f)) begin
					expect_store(16'd4, TAKEN_MARK);
					halt_pc = word_t'((pos + 2) * 2);
				end else begin
					expect_store(16'd2, NOT_TAKEN_MARK);
					halt_pc = word_t'(pos * 2);
				end
			end
			K_PCS: begin
				load_const(1, a);
				pos = prog.size();
				emit(enc_reg(OP_PCS, 3, 0, 0));
				emit(enc_mem(OP_SW, 3, 0, 4'd0));
				expect_store(16'h0000, word_t'(pos * 2 + 2));
			end
			default: begin
				load_const(1, a);
			end
		endcase
		if (r.kind != K_BRANCH) begin
			halt_pc = word_t'(prog.size() * 2);
			emit({OP_HLT, 12'h000});
		end
		// A halted core never fetches these stores past HLT
		if (r.kind == K_HALT) begin
			emit(enc_mem(OP_SW, 1, 0, 4'd3));
			emit(enc_mem(OP_SW, 1, 0, 4'd4));
		end
	endtask

	//////////////////////////////
	// Run control
	//////////////////////////////

	// Unused words hold HLT tagged with their own index
	task automatic load_program();
		for (int i = 0; i < 64; i++)
			imem[i] = (i < prog.size()) ? prog[i] : {OP_HLT, 12'(i)};
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#1 arst_n = 1'b0;
		load_program();
		st_addr.delete();
		st_data.delete();
		repeat (2) @(posedge clk);
		#1 arst_n = 1'b1;
	endtask

	task automatic wait_for_halt(input int row);
		int cycles;
		cycles = 0;
		while (hlt !== 1'b1) begin
			if (cycles >= HALT_TIMEOUT)
				abort_run($sformatf("Row %0d: hlt never rose, the program did not finish", row));
			@(negedge clk);
			cycles++;
		end
	endtask

	// Core must stay parked and silent
	task automatic watch_halted(input int row);
		for (int k = 0; k <= HOLD_CYCLES; k++) begin
			if (hlt !== 1'b1)
				abort_run($sformatf("Row %0d: hlt dropped after it was set", row));
			if (dmem_wr !== 1'b0)
				abort_run($sformatf("Row %0d: a store went out after halt", row));
			check_addr("pc", pc, halt_pc);
			if (k < HOLD_CYCLES)
				@(negedge clk);
		end
	endtask

	task automatic compare_stores(input int row);
		if (st_addr.size() != exp_addr.size())
			abort_run($sformatf("Row %0d: %0d stores seen but %0d expected", row,
				st_addr.size(), exp_addr.size()));
		foreach (exp_addr[k]) begin
			check_addr($sformatf("dmem_addr[%0d]", k), st_addr[k], exp_addr[k]);
			check_word($sformatf("dmem_wdata[%0d]", k), st_data[k], exp_data[k]);
		end
	endtask

	initial begin
		clk        = 1'b0;
		arst_n     = 1'b0;
		instr      = '0;
		dmem_rdata = '0;
		void'($urandom(32'h9b03_b333));
		// Word at byte address x starts as x ^ c3a5
		for (int i = 0; i < 32768; i++)
			dmem[i] = {i[14:0], 1'b0} ^ 16'hc3a5;
		foreach (rows[i]) begin
			build_program(rows[i]);
			apply_reset();
			wait_for_halt(i);
			watch_halted(i);
			compare_stores(i);
		end
		if (cpu_i.assert_i.fail_count == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
cpu_pkg.sv
cpu_fwd_if.sv
cpu_alu.sv
cpu_fetch.sv
cpu_decode.sv
cpu_execute.sv
cpu_memory.sv
cpu.sv
cpu_assert.sv
cpu_tb.sv
